// ==== Bender.yml ====
package:
  name: board_support

sources:
  - hw/lm_board_pkg.sv
  - hw/lm_mem_pkg.sv
  - hw/seq_timer.sv
  - hw/boot_sequencer.sv
  - hw/mem_port_ctrl.sv
  - hw/word_store.sv
  - hw/board_support_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/board_support_assertions.sv
      - tb/board_support_tb.sv

// ==== flist.f ====
hw/lm_board_pkg.sv
hw/lm_mem_pkg.sv
hw/seq_timer.sv
hw/boot_sequencer.sv
hw/mem_port_ctrl.sv
hw/word_store.sv
hw/board_support_top.sv
tb/clk_gen.sv
tb/board_support_assertions.sv
tb/board_support_tb.sv

// ==== hw/board_support_top.sv ====
// Board support top joining the boot sequencer, phase timer, memory port controller and store
`default_nettype none

module board_support_top import lm_board_pkg::*, lm_mem_pkg::*; #(
   parameter int DCM_CYCLES    = 4,
   parameter int CALIB_TIMEOUT = 64,
   parameter int RESET_CYCLES  = 6,
   parameter int STORE_AW      = 8
) (
   input  wire          clk50,
   input  wire          reset,
   input  wire          calib_done,
   input  wire mem_req_t sdram_req,
   input  wire mem_req_t vram_req,
   output mem_rsp_t     sdram_rsp,
   output mem_rsp_t     vram_rsp,
   output board_ctl_t   ctl,
   output logic [3:0]   led
);

   logic                timer_load;
   logic [TIMER_W-1:0]  timer_value;
   logic                timer_expired;
   logic                busy;
   logic [STORE_AW-1:0] st_addr;
   logic                st_we;
   logic [MEM_DW-1:0]   st_wdata;
   logic [MEM_DW-1:0]   st_rdata;

   ////////////////////////////////////////////////////////////////////
   // Reset and boot order

   boot_sequencer #(
      .DCM_CYCLES   (DCM_CYCLES),
      .CALIB_TIMEOUT(CALIB_TIMEOUT),
      .RESET_CYCLES (RESET_CYCLES)
   ) sequencer (
      .clk50        (clk50),
      .reset        (reset),
      .calib_done   (calib_done),
      .timer_expired(timer_expired),
      .timer_load   (timer_load),
      .timer_value  (timer_value),
      .ctl          (ctl)
   );

   seq_timer timer (
      .clk50  (clk50),
      .reset  (reset),
      .load   (timer_load),
      .value  (timer_value),
      .expired(timer_expired)
   );

   ////////////////////////////////////////////////////////////////////
   // Memory side

   mem_port_ctrl #(.STORE_AW(STORE_AW)) port_ctrl (
      .clk50    (clk50),
      .reset    (reset),
      .machrun  (ctl.machrun),             // Ports open once the machine runs
      .sdram_req(sdram_req),
      .vram_req (vram_req),
      .sdram_rsp(sdram_rsp),
      .vram_rsp (vram_rsp),
      .busy     (busy),
      .st_addr  (st_addr),
      .st_we    (st_we),
      .st_wdata (st_wdata),
      .st_rdata (st_rdata)
   );

   word_store #(.STORE_AW(STORE_AW)) store (
      .clk50(clk50),
      .addr (st_addr),
      .we   (st_we),
      .wdata(st_wdata),
      .rdata(st_rdata)
   );

   assign led = {busy, ctl.machrun, ctl.halt, ctl.cpu_reset};

endmodule

`default_nettype wire

// ==== hw/boot_sequencer.sv ====
// Boot sequencer FSM ordering clock manager, DRAM and CPU reset, then boot and run
`default_nettype none

module boot_sequencer import lm_board_pkg::*; #(
   parameter int DCM_CYCLES    = 4,
   parameter int CALIB_TIMEOUT = 64,
   parameter int RESET_CYCLES  = 6
) (
   input  wire                clk50,
   input  wire                reset,
   input  wire                calib_done,
   input  wire                timer_expired,
   output logic               timer_load,
   output logic [TIMER_W-1:0] timer_value,
   output board_ctl_t         ctl
);

   // Each timed phase spends one cycle on the load and one on the expiry,
   // so the counts are two short of the phase length (all counts >= 2)
   localparam logic [TIMER_W-1:0] DCM_LOAD   = TIMER_W'(DCM_CYCLES - 2);
   localparam logic [TIMER_W-1:0] CALIB_LOAD = TIMER_W'(CALIB_TIMEOUT - 2);
   localparam logic [TIMER_W-1:0] RESET_LOAD = TIMER_W'(RESET_CYCLES - 2);

   seq_state_e state;
   seq_state_e state_next;
   logic       phase_done;

   function automatic board_ctl_t decode_ctl(seq_state_e s);
      board_ctl_t c;
      c = '0;
      case (s)
         DCM_RST: begin
            c.dcm_reset   = 1'b1;
            c.lpddr_reset = 1'b1;
            c.cpu_reset   = 1'b1;
         end
         DRAM_RST: begin
            c.lpddr_reset = 1'b1;
            c.cpu_reset   = 1'b1;
         end
         CPU_RST:  c.cpu_reset = 1'b1;
         BOOT:     c.boot      = 1'b1;
         RUN:      c.machrun   = 1'b1;
         default: begin                    // HALTED keeps DRAM and CPU down
            c.lpddr_reset = 1'b1;
            c.cpu_reset   = 1'b1;
            c.halt        = 1'b1;
         end
      endcase
      return c;
   endfunction

   function automatic logic [TIMER_W-1:0] phase_load(seq_state_e s);
      case (s)
         DRAM_RST: return CALIB_LOAD;
         CPU_RST:  return RESET_LOAD;
         default:  return DCM_LOAD;
      endcase
   endfunction

   // A stale expiry from the previous phase may show during the load cycle
   assign phase_done = timer_expired && !timer_load;

   ////////////////////////////////////////////////////////////////////
   // Next state

   always_comb begin
      state_next = state;
      case (state)
         DCM_RST:  if (phase_done) state_next = DRAM_RST;
         DRAM_RST: begin
            if (calib_done)      state_next = CPU_RST;  // Calibration wins a tie
            else if (phase_done) state_next = HALTED;
         end
         CPU_RST:  if (phase_done) state_next = BOOT;
         BOOT:     state_next = RUN;
         RUN:      state_next = RUN;
         default:  state_next = HALTED;                 // Held until reset
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // State, outputs and timer control, all registered

   always_ff @(posedge clk50) begin
      if (reset) begin
         state       <= DCM_RST;
         ctl         <= decode_ctl(DCM_RST);
         timer_load  <= 1'b1;              // Start the clock manager phase
         timer_value <= DCM_LOAD;
      end else begin
         state       <= state_next;
         ctl         <= decode_ctl(state_next);
         timer_load  <= (state_next != state) &&
                        (state_next == DRAM_RST || state_next == CPU_RST);
         timer_value <= phase_load(state_next);
      end
   end

endmodule

`default_nettype wire

// ==== hw/lm_board_pkg.sv ====
// Board package with the reset and boot sequencer states and the board control word
`default_nettype none

package lm_board_pkg;

   localparam int TIMER_W = 16;            // Phase timer width

   ////////////////////////////////////////////////////////////////////
   // Sequencer states, in the order the board leaves reset

   typedef enum logic [2:0] {
      DCM_RST  = 3'd0,                     // Clock manager held in reset
      DRAM_RST = 3'd1,                     // Waiting for DRAM calibration
      CPU_RST  = 3'd2,                     // CPU reset after calibration
      BOOT     = 3'd3,                     // One-cycle boot pulse
      RUN      = 3'd4,
      HALTED   = 3'd5                      // Calibration timed out
   } seq_state_e;

   // Control and status lines driven by the sequencer
   typedef struct packed {
      logic dcm_reset;
      logic lpddr_reset;
      logic cpu_reset;
      logic boot;
      logic halt;
      logic machrun;
   } board_ctl_t;

endpackage

`default_nettype wire

// ==== hw/lm_mem_pkg.sv ====
// Memory package with client region codes and the req/ready/done request and response words
`default_nettype none

package lm_mem_pkg;

   localparam int MEM_AW = 22;             // Client word address width
   localparam int MEM_DW = 32;             // Data word width

   ////////////////////////////////////////////////////////////////////
   // Client codes, also the top bit of the store address

   typedef enum logic {
      SDRAM = 1'b0,                        // Main memory
      VRAM  = 1'b1                         // CPU side of video memory
   } mem_client_e;

   ////////////////////////////////////////////////////////////////////
   // Client strobes

   // Request from one client, req is a single-cycle strobe
   typedef struct packed {
      logic              req;
      logic              write;
      logic [MEM_AW-1:0] addr;
      logic [MEM_DW-1:0] data;             // Write data
   } mem_req_t;

   // Response to one client
   typedef struct packed {
      logic              ready;            // Level, request may be issued
      logic              done;             // One-cycle completion pulse
      logic [MEM_DW-1:0] data;             // Read or old word, valid with done
   } mem_rsp_t;

endpackage

`default_nettype wire

// ==== hw/mem_port_ctrl.sv ====
// Memory port controller, fixed-priority arbiter and two-stage pipeline for sdram and vram_cpu
`default_nettype none

module mem_port_ctrl import lm_mem_pkg::*; #(
   parameter int STORE_AW = 8
) (
   input  wire                clk50,
   input  wire                reset,
   input  wire                machrun,
   input  wire  mem_req_t     sdram_req,
   input  wire  mem_req_t     vram_req,
   output mem_rsp_t           sdram_rsp,
   output mem_rsp_t           vram_rsp,
   output logic               busy,
   output logic [STORE_AW-1:0] st_addr,
   output logic               st_we,
   output logic [MEM_DW-1:0]  st_wdata,
   input  wire  [MEM_DW-1:0]  st_rdata
);

   localparam int OFS_W = STORE_AW - 1;    // Word offset inside one region

   logic        ready;
   logic        sdram_go;
   logic        vram_go;

   // Held vram request after a collision
   logic        pend_valid;
   mem_req_t    pend_req;

   // Stage 1 drives the store, stage 2 meets its read data
   logic        s1_valid;
   mem_client_e s1_client;
   mem_req_t    s1_req;
   logic        s2_valid;
   mem_client_e s2_client;

   ////////////////////////////////////////////////////////////////////
   // Accept

   assign busy     = s1_valid | s2_valid | pend_valid;
   assign ready    = machrun && !busy;     // One request in flight at a time
   assign sdram_go = ready && sdram_req.req;
   assign vram_go  = ready && vram_req.req;

   always_ff @(posedge clk50) begin
      if (reset) begin
         pend_valid <= 1'b0;
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
      end else begin
         pend_valid <= sdram_go && vram_go;             // Collision, vram waits
         s1_valid   <= sdram_go | vram_go | pend_valid;
         s2_valid   <= s1_valid;
      end
   end

   // Payload and ownership, qualified by the valid bits
   always_ff @(posedge clk50) begin
      if (sdram_go) begin                  // sdram has priority
         s1_req    <= sdram_req;
         s1_client <= SDRAM;
      end else if (vram_go) begin
         s1_req    <= vram_req;
         s1_client <= VRAM;
      end else if (pend_valid) begin
         s1_req    <= pend_req;
         s1_client <= VRAM;
      end
      if (vram_go)
         pend_req <= vram_req;
      s2_client <= s1_client;
   end

   ////////////////////////////////////////////////////////////////////
   // Store port, region code above the word offset

   assign st_addr  = {s1_client, s1_req.addr[OFS_W-1:0]};
   assign st_we    = s1_valid && s1_req.write;
   assign st_wdata = s1_req.data;

   ////////////////////////////////////////////////////////////////////
   // Responses, read data steered to the owner of stage 2

   always_comb begin
      sdram_rsp.ready = ready;
      sdram_rsp.done  = s2_valid && (s2_client == SDRAM);
      sdram_rsp.data  = st_rdata;
      vram_rsp.ready  = ready;
      vram_rsp.done   = s2_valid && (s2_client == VRAM);
      vram_rsp.data   = st_rdata;
   end

endmodule

`default_nettype wire

// ==== hw/seq_timer.sv ====
// Phase timer, a loadable down-counter with a single expiry pulse
`default_nettype none

module seq_timer import lm_board_pkg::*; (
   input  wire               clk50,
   input  wire               reset,
   input  wire               load,
   input  wire [TIMER_W-1:0] value,
   output logic              expired
);

   logic [TIMER_W-1:0] count;
   logic               run;                // Counting toward zero

   always_ff @(posedge clk50) begin
      if (reset) begin
         count <= '0;
         run   <= 1'b0;
      end else if (load) begin             // Load overrides a running count
         count <= value;
         run   <= 1'b1;
      end else if (run) begin
         if (count == '0)
            run <= 1'b0;                   // Idle until the next load
         else
            count <= count - 1'b1;
      end
   end

   // High for the one cycle spent at zero
   assign expired = run && (count == '0);

endmodule

`default_nettype wire

// ==== hw/word_store.sv ====
// Word store, single-port read-before-write RAM standing in for the DRAM
`default_nettype none

module word_store import lm_mem_pkg::*; #(
   parameter int STORE_AW = 8
) (
   input  wire                 clk50,
   input  wire  [STORE_AW-1:0] addr,
   input  wire                 we,
   input  wire  [MEM_DW-1:0]   wdata,
   output logic [MEM_DW-1:0]   rdata
);

   localparam int DEPTH = 2 ** STORE_AW;   // Both regions, half each

   logic [MEM_DW-1:0] mem [DEPTH];

   ////////////////////////////////////////////////////////////////////
   // One access per cycle, data one cycle after the address

   always_ff @(posedge clk50) begin
      if (we)
         mem[addr] <= wdata;
      rdata <= mem[addr];                  // Old word on a write
   end

endmodule

`default_nettype wire

// ==== tb/board_support_assertions.sv ====
// Bound checks on memory done strobes, the boot pulse and the run sequencing
`default_nettype none

module board_support_assertions (
   input wire clk50,
   input wire reset,
   input wire sdram_done,
   input wire vram_done,
   input wire boot,
   input wire cpu_reset,
   input wire machrun
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;            // Read by the testbench at the end

   // Only one client owns the store data in any cycle
   one_done: assert property (@(posedge clk50) disable iff (reset)
      !(sdram_done && vram_done))
      else begin
         $error("sdram and vram done high in the same cycle");
         fail_count++;
      end

   boot_pulse: assert property (@(posedge clk50) disable iff (reset)
      $rose(boot) |=> !boot)
      else begin
         $error("boot held longer than one cycle");
         fail_count++;
      end

   run_after_reset: assert property (@(posedge clk50) disable iff (reset)
      $rose(machrun) |-> !cpu_reset)
      else begin
         $error("machrun rose with cpu_reset still high");
         fail_count++;
      end

endmodule

bind board_support_top board_support_assertions checks (
   .clk50     (clk50),
   .reset     (reset),
   .sdram_done(sdram_rsp.done),
   .vram_done (vram_rsp.done),
   .boot      (ctl.boot),
   .cpu_reset (ctl.cpu_reset),
   .machrun   (ctl.machrun)
);

`default_nettype wire

// ==== tb/board_support_tb.sv ====
// Testbench for board support, boot order, calibration timeout and memory port traffic
`default_nettype none

module board_support_tb import lm_board_pkg::*, lm_mem_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DCM_CYCLES    = 4;
   localparam int CALIB_TIMEOUT = 64;
   localparam int RESET_CYCLES  = 6;
   localparam int STORE_AW      = 8;
   localparam int OFS_W         = STORE_AW - 1;
   localparam int REGION_WORDS  = 2 ** OFS_W;
   localparam int CALIB_DELAY   = 10;      // Cycles from dcm_reset fall to calib_done
   localparam int WAIT_LIMIT    = 200;     // Cycles any single wait may take
   localparam int N_STEPS       = 12;

   typedef struct packed {
      mem_client_e       client;
      logic              write;
      logic [MEM_AW-1:0] addr;
      logic [MEM_DW-1:0] wdata;
      logic              known;            // Expected word is defined
      logic [MEM_DW-1:0] expect_data;      // Read word, or old word on a write
   } step_t;

   logic       clk50;
   logic       reset;
   logic       calib_done;
   mem_req_t   sdram_req;
   mem_req_t   vram_req;
   mem_rsp_t   sdram_rsp;
   mem_rsp_t   vram_rsp;
   board_ctl_t ctl;
   logic [3:0] led;

   int                errors;
   int                assert_fails;
   step_t             steps       [N_STEPS];
   logic [MEM_DW-1:0] sdram_model [REGION_WORDS];
   logic [MEM_DW-1:0] vram_model  [REGION_WORDS];
   logic              sdram_known [REGION_WORDS];
   logic              vram_known  [REGION_WORDS];

   clk_gen #(.PERIOD(100)) clock (.clk50(clk50));

   board_support_top #(
      .DCM_CYCLES   (DCM_CYCLES),
      .CALIB_TIMEOUT(CALIB_TIMEOUT),
      .RESET_CYCLES (RESET_CYCLES),
      .STORE_AW     (STORE_AW)
   ) uut (
      .clk50     (clk50),
      .reset     (reset),
      .calib_done(calib_done),
      .sdram_req (sdram_req),
      .vram_req  (vram_req),
      .sdram_rsp (sdram_rsp),
      .vram_rsp  (vram_rsp),
      .ctl       (ctl),
      .led       (led)
   );

   //////////////////////////////////////////////////////////////////////
   // Reporting and helpers

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR: %s", what);
   endtask

   function automatic mem_req_t make_req(input logic write, input logic [MEM_AW-1:0] addr,
                                         input logic [MEM_DW-1:0] data);
      mem_req_t r;
      r.req   = 1'b1;
      r.write = write;
      r.addr  = addr;
      r.data  = data;
      return r;
   endfunction

   function automatic mem_rsp_t rsp_of(input mem_client_e client);
      return (client == SDRAM) ? sdram_rsp : vram_rsp;
   endfunction

   // Next table entry, expected word from the region model
   task automatic plan_step(input mem_client_e client, input logic write,
                            input logic [MEM_AW-1:0] addr, output step_t s);
      logic [OFS_W-1:0] ofs;
      ofs      = addr[OFS_W-1:0];          // Upper address bits fall outside a region
      s.client = client;
      s.write  = write;
      s.addr   = addr;
      s.wdata  = write ? $urandom : '0;
      if (client == SDRAM) begin
         s.known       = sdram_known[ofs];
         s.expect_data = sdram_model[ofs];
         if (write) begin
            sdram_model[ofs] = s.wdata;
            sdram_known[ofs] = 1'b1;
         end
      end else begin
         s.known       = vram_known[ofs];
         s.expect_data = vram_model[ofs];
         if (write) begin
            vram_model[ofs] = s.wdata;
            vram_known[ofs] = 1'b1;
         end
      end
   endtask

   task automatic build_table();
      plan_step(SDRAM, 1'b1, 22'h000010, steps[0]);
      plan_step(VRAM,  1'b1, 22'h000010, steps[1]);   // Same offset, other region
      plan_step(SDRAM, 1'b1, 22'h000023, steps[2]);
      plan_step(VRAM,  1'b1, 22'h00007f, steps[3]);
      plan_step(SDRAM, 1'b0, 22'h000010, steps[4]);
      plan_step(VRAM,  1'b0, 22'h000010, steps[5]);
      plan_step(SDRAM, 1'b0, 22'h000023, steps[6]);
      plan_step(VRAM,  1'b0, 22'h00007f, steps[7]);
      plan_step(SDRAM, 1'b1, 22'h000010, steps[8]);   // Old word comes back
      plan_step(VRAM,  1'b1, 22'h000010, steps[9]);
      plan_step(SDRAM, 1'b0, 22'h100010, steps[10]);
      plan_step(VRAM,  1'b0, 22'h000010, steps[11]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Waits

   task automatic hold_reset();
      repeat (2) @(posedge clk50);
      reset <= 1'b0;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk50);
      while (!(sdram_rsp.ready && vram_rsp.ready) && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk50);
      end
      if (n >= WAIT_LIMIT)
         report_failure("timeout waiting for ready");
   endtask

   // Starts right after reset is released
   task automatic wait_dcm_release();
      int n;
      @(negedge clk50);
      if (ctl !== 6'b111000)               // All three resets held
         report_mismatch("ctl", ctl, 6'b111000);
      if (led !== 4'b0001)
         report_mismatch("led", led, 4'b0001);
      n = 0;
      while (ctl.dcm_reset && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk50);
      end
      if (n >= WAIT_LIMIT)
         report_failure("dcm_reset never fell");
      else if (n != DCM_CYCLES)
         report_mismatch("dcm_reset cycles", n, DCM_CYCLES);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Behaviors

   task automatic check_boot();
      int n;
      wait_dcm_release();
      repeat (CALIB_DELAY) @(posedge clk50);
      calib_done <= 1'b1;
      n = 0;
      @(negedge clk50);
      while (ctl.lpddr_reset && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk50);
      end
      if (n >= WAIT_LIMIT)
         report_failure("lpddr_reset never fell after calib_done");
      else if (n != 1)
         report_mismatch("lpddr_reset delay", n, 1);
      n = 0;
      while (ctl.cpu_reset && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk50);
      end
      if (n >= WAIT_LIMIT)
         report_failure("cpu_reset never fell");
      else if (n != RESET_CYCLES)
         report_mismatch("cpu_reset cycles", n, RESET_CYCLES);
      if (ctl !== 6'b000100)               // Boot pulse only
         report_mismatch("ctl", ctl, 6'b000100);
      if (led !== 4'b0000)
         report_mismatch("led", led, 4'b0000);
      @(negedge clk50);
      if (ctl !== 6'b000001)
         report_mismatch("ctl", ctl, 6'b000001);
      if (led !== 4'b0100)
         report_mismatch("led", led, 4'b0100);
   endtask

   task automatic run_step(input step_t s);
      int       lat;
      mem_rsp_t r;
      string    port;
      port = (s.client == SDRAM) ? "sdram_rsp.data" : "vram_rsp.data";
      wait_ready();
      @(posedge clk50);
      if (s.client == SDRAM)
         sdram_req <= make_req(s.write, s.addr, s.wdata);
      else
         vram_req <= make_req(s.write, s.addr, s.wdata);
      @(posedge clk50);
      sdram_req.req <= 1'b0;
      vram_req.req  <= 1'b0;
      @(negedge clk50);
      if (sdram_rsp.ready !== 1'b0 || vram_rsp.ready !== 1'b0)
         report_failure("ready stayed high after a request");
      if (led[3] !== 1'b1)
         report_mismatch("led[3]", led[3], 1'b1);
      lat = 1;
      r = rsp_of(s.client);
      while (!r.done && lat < WAIT_LIMIT) begin
         lat++;
         @(negedge clk50);
         r = rsp_of(s.client);
      end
      if (!r.done) begin
         report_failure("timeout waiting for done");
      end else begin
         if (lat != 2)
            report_mismatch("done latency", lat, 2);
         if (s.known && r.data !== s.expect_data)
            report_mismatch(port, r.data, s.expect_data);
         @(negedge clk50);
         if (sdram_rsp.ready !== 1'b1 || vram_rsp.ready !== 1'b1)
            report_failure("ready did not return the cycle after done");
      end
   endtask

   task automatic check_collision();
      step_t sd;
      step_t vr;
      step_t rb;
      int    n;
      int    sd_at;
      int    vr_at;
      plan_step(SDRAM, 1'b0, 22'h000023, sd);
      plan_step(VRAM,  1'b1, 22'h000010, vr);
      plan_step(VRAM,  1'b0, 22'h000010, rb);
      wait_ready();
      @(posedge clk50);
      sdram_req <= make_req(sd.write, sd.addr, sd.wdata);
      vram_req  <= make_req(vr.write, vr.addr, vr.wdata);
      @(posedge clk50);
      sdram_req.req <= 1'b0;
      vram_req.req  <= 1'b0;
      n     = 1;
      sd_at = 0;
      vr_at = 0;
      @(negedge clk50);
      while ((sd_at == 0 || vr_at == 0) && n < WAIT_LIMIT) begin
         if (sdram_rsp.done) begin
            sd_at = n;
            if (sdram_rsp.data !== sd.expect_data)
               report_mismatch("sdram_rsp.data", sdram_rsp.data, sd.expect_data);
         end
         if (vram_rsp.done) begin
            vr_at = n;
            if (vram_rsp.data !== vr.expect_data)
               report_mismatch("vram_rsp.data", vram_rsp.data, vr.expect_data);
         end
         n++;
         @(negedge clk50);
      end
      if (sd_at == 0 || vr_at == 0) begin
         report_failure("timeout waiting for both done pulses after a collision");
      end else begin
         if (sd_at != 2)
            report_mismatch("sdram done latency", sd_at, 2);
         if (vr_at <= sd_at)
            report_failure("vram done did not follow sdram done");
      end
      run_step(rb);                        // New vram word is in place
   endtask

   task automatic check_timeout();
      int n;
      @(posedge clk50);
      reset      <= 1'b1;
      calib_done <= 1'b0;
      hold_reset();
      wait_dcm_release();
      n = 0;
      while (!ctl.halt && n < WAIT_LIMIT) begin
         if (ctl.machrun !== 1'b0 || sdram_rsp.ready !== 1'b0 || vram_rsp.ready !== 1'b0)
            report_failure("machine opened without calibration");
         n++;
         @(negedge clk50);
      end
      if (n >= WAIT_LIMIT)
         report_failure("halt never rose without calibration");
      else if (n != CALIB_TIMEOUT)
         report_mismatch("halt delay", n, CALIB_TIMEOUT);
      repeat (16) begin
         if (ctl !== 6'b011010)            // DRAM and CPU down, halted
            report_mismatch("ctl", ctl, 6'b011010);
         if (led !== 4'b0011)
            report_mismatch("led", led, 4'b0011);
         if (sdram_rsp.ready !== 1'b0 || vram_rsp.ready !== 1'b0)
            report_failure("ready high while halted");
         @(negedge clk50);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      void'($urandom(32'he57b_909d));
      reset      = 1'b1;
      calib_done = 1'b0;
      sdram_req  = '0;
      vram_req   = '0;
      errors     = 0;
      for (int i = 0; i < REGION_WORDS; i++) begin
         sdram_known[i] = 1'b0;
         vram_known[i]  = 1'b0;
      end
      build_table();
      hold_reset();
      check_boot();
      for (int i = 0; i < N_STEPS; i++)
         run_step(steps[i]);
      check_collision();
      check_timeout();
      assert_fails = uut.checks.fail_count;
      $display("Errors: %0d testbench, %0d assertion", errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
// Clock generator, free-running clk50 for the testbench
`default_nettype none

module clk_gen #(
   parameter int PERIOD = 100              // ns
) (
   output logic clk50
);

   timeunit 1ns;
   timeprecision 100ps;

   initial clk50 = 1'b0;

   always #(PERIOD / 2) clk50 = ~clk50;

endmodule

`default_nettype wire
